// ==== hw/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Datapath widths.
`define FETCH_XLEN 32
`define FETCH_LINE_WD 128

// Instruction buffer geometry.
`define FETCH_IB_DEPTH 8
`define FETCH_IB_DEPTH_LOG2 3

// First fetch address after reset.
`define FETCH_RESET_PC 32'h1c00_0000

// Fetch address error, reported for a misaligned PC.
`define FETCH_ECODE_ADEF 6'h08
`define FETCH_ESUBCODE_ADEF 9'h000

`endif

// ==== hw/fetch_pkg.sv ====
`include "fetch_params.svh"

package fetch_pkg;

  // One buffer entry word.
  // The excp flag kept beside it selects the view.
  typedef union packed {
    logic [`FETCH_XLEN-1:0] instr;
    struct packed {
      logic [5:0]  ecode;
      logic [8:0]  esubcode;
      logic [16:0] rsvd;
    } excp;
  } ib_payload_u;

endpackage

// ==== hw/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_pc_gen (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   redirect_valid,
  input  logic [`FETCH_XLEN-1:0] redirect_pc,
  input  logic                   pc_advance,
  output logic [`FETCH_XLEN-1:0] fetch_pc,
  output logic                   pc_misaligned
);

  logic [`FETCH_XLEN-1:0] next_line_pc;

  // Next 16-byte boundary, so a mid-line target continues on aligned lines.
  assign next_line_pc = {fetch_pc[`FETCH_XLEN-1:4] + 28'd1, 4'b0000};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fetch_pc <= `FETCH_RESET_PC;
    end
    else if (redirect_valid)
    begin
      fetch_pc <= redirect_pc;
    end
    else if (pc_advance)
    begin
      fetch_pc <= next_line_pc;
    end
  end

  assign pc_misaligned = |fetch_pc[1:0];

endmodule

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      redirect_valid,
  input  logic [`FETCH_XLEN-1:0]    fetch_pc,
  input  logic                      pc_misaligned,
  input  logic                      align_ready,
  output logic                      mem_req,
  output logic [`FETCH_XLEN-1:0]    mem_addr,
  input  logic                      mem_ack,
  input  logic [`FETCH_LINE_WD-1:0] mem_rdata,
  output logic                      line_valid,
  output logic [`FETCH_LINE_WD-1:0] line_data,
  output logic [`FETCH_XLEN-1:0]    line_pc,
  output logic                      excp_valid,
  output logic                      pc_advance
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_REL  = 2'd2;
  localparam logic [1:0] S_HALT = 2'd3;

  logic [1:0] state;
  logic       drop;
  logic       issue;
  logic       fault;
  logic       take;

  // Nothing starts in the cycle a redirect loads the PC.
  assign issue = (state == S_IDLE) && !redirect_valid && align_ready &&
                 !mem_ack && !pc_misaligned;
  assign fault = (state == S_IDLE) && !redirect_valid && align_ready && pc_misaligned;

  // A response after a redirect finishes the handshake but is not used.
  assign take = (state == S_REQ) && mem_ack && !drop && !redirect_valid;

  assign pc_advance = take;
  assign mem_req    = (state == S_REQ);
  assign mem_addr   = {line_pc[`FETCH_XLEN-1:4], 4'b0000};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= S_IDLE;
      drop       <= 1'b0;
      line_valid <= 1'b0;
      excp_valid <= 1'b0;
    end
    else
    begin
      line_valid <= take;
      excp_valid <= fault;
      case (state)
        S_IDLE:
        begin
          if (issue)
            state <= S_REQ;
          else if (fault)
            state <= S_HALT;
        end
        S_REQ:
        begin
          if (mem_ack)
            state <= S_REL;
          if (redirect_valid)
            drop <= 1'b1;
        end
        S_REL:
        begin
          // Wait for the memory to drop ack.
          if (!mem_ack)
          begin
            state <= S_IDLE;
            drop  <= 1'b0;
          end
        end
        default:
        begin
          if (redirect_valid)
            state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue || fault)
      line_pc <= fetch_pc;
    if (take)
      line_data <= mem_rdata;
  end

  a_req_after_ack_low: assert property (
    @(posedge clk) disable iff (rst) $rose(mem_req) |-> !$past(mem_ack));

  a_line_excp_excl: assert property (
    @(posedge clk) disable iff (rst) !(line_valid && excp_valid));

endmodule

// ==== hw/fetch_align.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_align (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         redirect_valid,
  input  logic                         line_valid,
  input  logic [`FETCH_LINE_WD-1:0]    line_data,
  input  logic [`FETCH_XLEN-1:0]       line_pc,
  input  logic                         excp_valid,
  input  logic [`FETCH_IB_DEPTH_LOG2:0] free_count,
  output logic                         align_ready,
  output logic [2:0]                   push_num,
  output fetch_pkg::ib_payload_u       slot0_payload,
  output fetch_pkg::ib_payload_u       slot1_payload,
  output fetch_pkg::ib_payload_u       slot2_payload,
  output fetch_pkg::ib_payload_u       slot3_payload,
  output logic [`FETCH_XLEN-1:0]       slot0_pc,
  output logic [`FETCH_XLEN-1:0]       slot1_pc,
  output logic [`FETCH_XLEN-1:0]       slot2_pc,
  output logic [`FETCH_XLEN-1:0]       slot3_pc,
  output logic                         slot0_excp,
  output logic                         slot1_excp,
  output logic                         slot2_excp,
  output logic                         slot3_excp
);

  fetch_pkg::ib_payload_u new_payload [4];
  logic [`FETCH_XLEN-1:0] new_pc      [4];
  logic                   new_excp    [4];
  fetch_pkg::ib_payload_u sb_payload  [4];
  logic [`FETCH_XLEN-1:0] sb_pc       [4];
  logic                   sb_excp     [4];
  fetch_pkg::ib_payload_u out_payload [4];
  logic [`FETCH_XLEN-1:0] out_pc      [4];
  logic                   out_excp    [4];

  logic       new_valid;
  logic [2:0] new_num;
  logic       new_fits;
  logic       sb_valid;
  logic [2:0] sb_num;
  logic       sb_fits;

  assign new_valid = (line_valid || excp_valid) && !redirect_valid;
  assign new_num   = excp_valid ? 3'd1 : 3'd4 - {1'b0, line_pc[3:2]};
  assign new_fits  = free_count >= {1'b0, new_num};
  assign sb_fits   = free_count >= {1'b0, sb_num};

  for (genvar i = 0; i < 4; i++)
  begin : g_slot
    logic [1:0]             idx;
    fetch_pkg::ib_payload_u payload;

    // Slot i takes the word i places after the entry word.
    assign idx = line_pc[3:2] + 2'(i);

    always_comb
    begin
      payload.instr = line_data[`FETCH_XLEN*idx +: `FETCH_XLEN];
      if (excp_valid)
      begin
        payload.excp.ecode    = `FETCH_ECODE_ADEF;
        payload.excp.esubcode = `FETCH_ESUBCODE_ADEF;
        payload.excp.rsvd     = '0;
      end
    end

    assign new_payload[i] = payload;
    assign new_pc[i]      = excp_valid ? line_pc : {line_pc[`FETCH_XLEN-1:4], idx, 2'b00};
    assign new_excp[i]    = excp_valid;

    // The store buffer goes first while it holds a block.
    assign out_payload[i] = sb_valid ? sb_payload[i] : new_payload[i];
    assign out_pc[i]      = sb_valid ? sb_pc[i] : new_pc[i];
    assign out_excp[i]    = sb_valid ? sb_excp[i] : new_excp[i];
  end

  always_comb
  begin
    push_num = 3'd0;
    if (!redirect_valid)
    begin
      if (sb_valid)
      begin
        if (sb_fits)
          push_num = sb_num;
      end
      else if (new_valid && new_fits)
      begin
        push_num = new_num;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || redirect_valid)
    begin
      sb_valid <= 1'b0;
      sb_num   <= 3'd0;
    end
    else if (sb_valid)
    begin
      if (sb_fits)
        sb_valid <= 1'b0;
    end
    else if (new_valid && !new_fits)
    begin
      sb_valid <= 1'b1;
      sb_num   <= new_num;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sb_valid && new_valid && !new_fits)
    begin
      sb_payload <= new_payload;
      sb_pc      <= new_pc;
      sb_excp    <= new_excp;
    end
  end

  assign align_ready = !sb_valid;

  assign slot0_payload = out_payload[0];
  assign slot1_payload = out_payload[1];
  assign slot2_payload = out_payload[2];
  assign slot3_payload = out_payload[3];
  assign slot0_pc      = out_pc[0];
  assign slot1_pc      = out_pc[1];
  assign slot2_pc      = out_pc[2];
  assign slot3_pc      = out_pc[3];
  assign slot0_excp    = out_excp[0];
  assign slot1_excp    = out_excp[1];
  assign slot2_excp    = out_excp[2];
  assign slot3_excp    = out_excp[3];

  a_push_fits: assert property (
    @(posedge clk) disable iff (rst) {1'b0, push_num} <= free_count);

endmodule

// ==== hw/instr_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_buffer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          redirect_valid,
  input  logic [2:0]                    push_num,
  input  fetch_pkg::ib_payload_u        slot0_payload,
  input  fetch_pkg::ib_payload_u        slot1_payload,
  input  fetch_pkg::ib_payload_u        slot2_payload,
  input  fetch_pkg::ib_payload_u        slot3_payload,
  input  logic [`FETCH_XLEN-1:0]        slot0_pc,
  input  logic [`FETCH_XLEN-1:0]        slot1_pc,
  input  logic [`FETCH_XLEN-1:0]        slot2_pc,
  input  logic [`FETCH_XLEN-1:0]        slot3_pc,
  input  logic                          slot0_excp,
  input  logic                          slot1_excp,
  input  logic                          slot2_excp,
  input  logic                          slot3_excp,
  output logic [`FETCH_IB_DEPTH_LOG2:0] free_count,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [`FETCH_XLEN-1:0]        out_pc,
  output logic                          out_excp,
  output fetch_pkg::ib_payload_u        out_payload
);

  localparam int AW = `FETCH_IB_DEPTH_LOG2;
  localparam int CW = AW + 1;
  localparam logic [CW-1:0] DEPTH_CNT = `FETCH_IB_DEPTH;

  fetch_pkg::ib_payload_u buf_payload [`FETCH_IB_DEPTH];
  logic [`FETCH_XLEN-1:0] buf_pc      [`FETCH_IB_DEPTH];
  logic                   buf_excp    [`FETCH_IB_DEPTH];

  fetch_pkg::ib_payload_u in_payload [4];
  logic [`FETCH_XLEN-1:0] in_pc      [4];
  logic                   in_excp    [4];

  logic [AW-1:0] head;
  logic [AW-1:0] tail;
  logic [CW-1:0] count;
  logic          pop;

  assign in_payload[0] = slot0_payload;
  assign in_payload[1] = slot1_payload;
  assign in_payload[2] = slot2_payload;
  assign in_payload[3] = slot3_payload;
  assign in_pc[0]      = slot0_pc;
  assign in_pc[1]      = slot1_pc;
  assign in_pc[2]      = slot2_pc;
  assign in_pc[3]      = slot3_pc;
  assign in_excp[0]    = slot0_excp;
  assign in_excp[1]    = slot1_excp;
  assign in_excp[2]    = slot2_excp;
  assign in_excp[3]    = slot3_excp;

  assign out_valid   = (count != '0);
  assign pop         = out_valid && out_ready;
  assign free_count  = DEPTH_CNT - count;
  assign out_payload = buf_payload[head];
  assign out_pc      = buf_pc[head];
  assign out_excp    = buf_excp[head];

  // Slots land at consecutive positions from the tail, wrapping.
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (3'(i) < push_num)
      begin
        buf_payload[tail + AW'(i)] <= in_payload[i];
        buf_pc[tail + AW'(i)]      <= in_pc[i];
        buf_excp[tail + AW'(i)]    <= in_excp[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || redirect_valid)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      head  <= head + AW'(pop);
      tail  <= tail + AW'(push_num);
      count <= count + CW'(push_num) - CW'(pop);
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst) free_count <= DEPTH_CNT);

endmodule

// ==== hw/fetch_frontend.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_frontend (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      redirect_valid,
  input  logic [`FETCH_XLEN-1:0]    redirect_pc,
  output logic                      mem_req,
  output logic [`FETCH_XLEN-1:0]    mem_addr,
  input  logic                      mem_ack,
  input  logic [`FETCH_LINE_WD-1:0] mem_rdata,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`FETCH_XLEN-1:0]    out_pc,
  output logic                      out_excp,
  output fetch_pkg::ib_payload_u    out_payload
);

  logic [`FETCH_XLEN-1:0]        fetch_pc;
  logic                          pc_misaligned;
  logic                          pc_advance;
  logic                          align_ready;
  logic                          line_valid;
  logic [`FETCH_LINE_WD-1:0]     line_data;
  logic [`FETCH_XLEN-1:0]        line_pc;
  logic                          excp_valid;
  logic [2:0]                    push_num;
  logic [`FETCH_IB_DEPTH_LOG2:0] free_count;
  fetch_pkg::ib_payload_u        slot0_payload;
  fetch_pkg::ib_payload_u        slot1_payload;
  fetch_pkg::ib_payload_u        slot2_payload;
  fetch_pkg::ib_payload_u        slot3_payload;
  logic [`FETCH_XLEN-1:0]        slot0_pc;
  logic [`FETCH_XLEN-1:0]        slot1_pc;
  logic [`FETCH_XLEN-1:0]        slot2_pc;
  logic [`FETCH_XLEN-1:0]        slot3_pc;
  logic                          slot0_excp;
  logic                          slot1_excp;
  logic                          slot2_excp;
  logic                          slot3_excp;

  fetch_pc_gen u_pc_gen (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pc_advance     (pc_advance),
    .fetch_pc       (fetch_pc),
    .pc_misaligned  (pc_misaligned)
  );

  fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .fetch_pc       (fetch_pc),
    .pc_misaligned  (pc_misaligned),
    .align_ready    (align_ready),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .line_valid     (line_valid),
    .line_data      (line_data),
    .line_pc        (line_pc),
    .excp_valid     (excp_valid),
    .pc_advance     (pc_advance)
  );

  fetch_align u_align (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .line_valid     (line_valid),
    .line_data      (line_data),
    .line_pc        (line_pc),
    .excp_valid     (excp_valid),
    .free_count     (free_count),
    .align_ready    (align_ready),
    .push_num       (push_num),
    .slot0_payload  (slot0_payload),
    .slot1_payload  (slot1_payload),
    .slot2_payload  (slot2_payload),
    .slot3_payload  (slot3_payload),
    .slot0_pc       (slot0_pc),
    .slot1_pc       (slot1_pc),
    .slot2_pc       (slot2_pc),
    .slot3_pc       (slot3_pc),
    .slot0_excp     (slot0_excp),
    .slot1_excp     (slot1_excp),
    .slot2_excp     (slot2_excp),
    .slot3_excp     (slot3_excp)
  );

  instr_buffer u_ib (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .push_num       (push_num),
    .slot0_payload  (slot0_payload),
    .slot1_payload  (slot1_payload),
    .slot2_payload  (slot2_payload),
    .slot3_payload  (slot3_payload),
    .slot0_pc       (slot0_pc),
    .slot1_pc       (slot1_pc),
    .slot2_pc       (slot2_pc),
    .slot3_pc       (slot3_pc),
    .slot0_excp     (slot0_excp),
    .slot1_excp     (slot1_excp),
    .slot2_excp     (slot2_excp),
    .slot3_excp     (slot3_excp),
    .free_count     (free_count),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_excp       (out_excp),
    .out_payload    (out_payload)
  );

endmodule

// ==== bench/fetch_mem_model.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_mem_model (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mem_req,
  input  logic [`FETCH_XLEN-1:0]    mem_addr,
  output logic                      mem_ack,
  output logic [`FETCH_LINE_WD-1:0] mem_rdata
);

  localparam logic [31:0] SEED = 32'd76;

  logic [31:0] rnd_state;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Word i of a line holds its own byte address XOR a fixed mask.
  function automatic logic [`FETCH_LINE_WD-1:0] line_pattern(input logic [31:0] addr);
    logic [`FETCH_LINE_WD-1:0] line;
    for (int i = 0; i < 4; i++)
      line[32*i +: 32] = (addr + 32'(4 * i)) ^ 32'ha5a5_a5a5;
    return line;
  endfunction

  initial
  begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    rnd_state = SEED;
    forever
    begin
      @(negedge clk);
      if (!rst && mem_req && !mem_ack)
      begin
        // Random latency of 0 to 5 cycles.
        rnd_state = xorshift32(rnd_state);
        repeat (rnd_state % 32'd6) @(negedge clk);
        mem_rdata = line_pattern(mem_addr);
        mem_ack   = 1'b1;
        while (mem_req)
          @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

endmodule

// ==== bench/fetch_frontend_tb.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_frontend_tb;

  localparam int          NUM_ROWS        = 7;
  localparam int          RESET_CYCLES    = 8;
  localparam int          HALT_CYCLES     = 40;
  localparam int          WATCHDOG_CYCLES = 200 * NUM_ROWS + RESET_CYCLES;
  localparam logic [31:0] SEED            = 32'd76;

  // Each row holds reset start, target PC, entries to take, ready percent
  // and whether the redirect waits for an open memory request.
  localparam bit ROW_FROM_RESET [NUM_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
  localparam logic [31:0] ROW_PC [NUM_ROWS] = '{
    `FETCH_RESET_PC, 32'h1c00_0108, 32'h1c00_1000, 32'h1c00_2004,
    32'h1c00_3002, 32'h1c00_4000, 32'h1c00_500c};
  localparam int ROW_COUNT [NUM_ROWS] = '{12, 10, 40, 8, 1, 16, 20};
  localparam int ROW_READY [NUM_ROWS] = '{100, 100, 30, 100, 100, 50, 30};
  localparam bit ROW_OPEN_REQ [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

  logic                      clk;
  logic                      rst;
  logic                      redirect_valid;
  logic [`FETCH_XLEN-1:0]    redirect_pc;
  logic                      mem_req;
  logic [`FETCH_XLEN-1:0]    mem_addr;
  logic                      mem_ack;
  logic [`FETCH_LINE_WD-1:0] mem_rdata;
  logic                      out_valid;
  logic                      out_ready;
  logic [`FETCH_XLEN-1:0]    out_pc;
  logic                      out_excp;
  fetch_pkg::ib_payload_u    out_payload;
  logic [31:0]               rnd_state;

  fetch_frontend u_dut (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_excp       (out_excp),
    .out_payload    (out_payload)
  );

  fetch_mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] pc);
    return pc ^ 32'ha5a5_a5a5;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // Entry at the decode port, sampled while it is stable before the transfer edge.
  task automatic check_entry(input logic [31:0] pc);
    check_value(out_pc, pc, "entry pc");
    if (|pc[1:0])
    begin
      check_value(32'(out_excp), 32'd1, "exception flag");
      check_value(32'(out_payload.excp.ecode), 32'(`FETCH_ECODE_ADEF), "ecode");
      check_value(32'(out_payload.excp.esubcode), 32'(`FETCH_ESUBCODE_ADEF), "esubcode");
      check_value(32'(out_payload.excp.rsvd), 32'd0, "reserved bits");
    end
    else
    begin
      check_value(32'(out_excp), 32'd0, "exception flag");
      check_value(out_payload.instr, expected_word(pc), "instruction word");
    end
  endtask

  // After a fault, fetch must stay idle until the next redirect.
  task automatic check_halt(input int cycles);
    repeat (cycles)
    begin
      check_value(32'(mem_req), 32'd0, "mem_req while halted");
      check_value(32'(out_valid), 32'd0, "out_valid while halted");
      @(negedge clk);
    end
  endtask

  // Drain old entries until a request is seen open, then return on a falling edge.
  task automatic wait_open_request();
    logic open;
    open      = 1'b0;
    out_ready = 1'b1;
    while (!open)
    begin
      @(posedge clk);
      #1;
      open = mem_req;
    end
    @(negedge clk);
  endtask

  task automatic run_row(input int r);
    int          consumed;
    logic [31:0] exp_pc;
    logic        ready;
    if (!ROW_FROM_RESET[r])
    begin
      if (ROW_OPEN_REQ[r])
        wait_open_request();
      redirect_valid = 1'b1;
      redirect_pc    = ROW_PC[r];
      out_ready      = 1'b0;
      @(negedge clk);
      redirect_valid = 1'b0;
    end
    exp_pc   = ROW_PC[r];
    consumed = 0;
    while (consumed < ROW_COUNT[r])
    begin
      rnd_state = xorshift32(rnd_state);
      ready     = (rnd_state % 32'd100) < 32'(ROW_READY[r]);
      out_ready = ready;
      if (out_valid && ready)
      begin
        check_entry(exp_pc);
        consumed++;
        exp_pc = exp_pc + 32'd4;
      end
      @(negedge clk);
    end
    out_ready = 1'b0;
    if (|ROW_PC[r][1:0])
      check_halt(HALT_CYCLES);
  endtask

  // An open request always names a whole memory line.
  always @(negedge clk)
  begin
    if (!rst && mem_req)
      check_value(32'(mem_addr[3:0]), 32'd0, "mem_addr line offset");
  end

  initial
  begin
    clk            = 1'b0;
    rst            = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    out_ready      = 1'b0;
    rnd_state      = SEED;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    $display("test passed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, the frontend stopped delivering the expected entries");
    $display("test failed");
    $fatal(1);
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_pc_gen.sv
hw/fetch_ctrl.sv
hw/fetch_align.sv
hw/instr_buffer.sv
hw/fetch_frontend.sv
bench/fetch_mem_model.sv
bench/fetch_frontend_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch frontend testbench.

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The binary exits non-zero when the testbench stops with $fatal.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
